// ==== Makefile ====
TOP = pma_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

# Pass only if the run prints the pass message
sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== files.f ====
source/pma_cfg_pkg.sv
source/mem_access_pkg.sv
source/pma_lookup_if.sv
source/pma_fault_if.sv
source/pma_apb_regs.sv
source/pma_checker.sv
source/pma_fault_report.sv
source/pma_top.sv
verif/pma_props.sv
verif/pma_scoreboard.sv
verif/pma_tb.sv

// ==== source/mem_access_pkg.sv ====
package mem_access_pkg;

  // Address width of the core bus
  localparam int ADDR_W_DEFAULT = 32;

  // RISC-V mcause exception codes for access faults
  // NoFault fills the cause while nothing is reported
  typedef enum logic [3:0] {
    NoFault          = 4'd0,
    InstrAccessFault = 4'd1,
    LoadAccessFault  = 4'd5,
    StoreAccessFault = 4'd7
  } fault_cause_t;

endpackage

// ==== source/pma_apb_regs.sv ====
`timescale 1ns/1ps

module pma_apb_regs #(
  parameter int REGION_BITS = 4
) (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  pma_lookup_if.regs  lookup
);

  import pma_cfg_pkg::*;

  localparam int NUM_REGS = 2 ** REGION_BITS;

  // Attribute register table
  pma_reg_t regs [NUM_REGS];

  logic [REGION_BITS-1:0] reg_idx;
  logic                   in_range;
  logic                   access;
  logic                   wr_en;
  pma_reg_t               wr_raw;
  pma_reg_t               wr_legal;

  // WARL fix-up of one region config
  function automatic pma_cfg_t legalize(input pma_cfg_t cfg);
    pma_cfg_t res;
    res = cfg;
    // Reserved reservability falls back to none
    if (res.Rsrv == RsrvReserved) begin
      res.Rsrv = RsrvNone;
    end
    // Reserved width falls back to word
    if (res.AccWidth == AccWidthReserved) begin
      res.AccWidth = WordAcc;
    end
    return res;
  endfunction

  // Default map of a register after reset
  function automatic pma_reg_t reset_value(input int unsigned idx);
    pma_reg_t val;
    if (idx == 0) begin
      // Boot ROM below RAM in the first region pair
      val.pma_cfg_1 = RAM_CFG;
      val.pma_cfg_0 = ROM_CFG;
    end else if (idx < NUM_REGS / 2) begin
      val.pma_cfg_1 = RAM_CFG;
      val.pma_cfg_0 = RAM_CFG;
    end else begin
      // Upper address space is I/O
      val.pma_cfg_1 = IO_CFG;
      val.pma_cfg_0 = IO_CFG;
    end
    return val;
  endfunction

  // Word offset selects the register
  assign reg_idx = paddr_i[REGION_BITS+1:2];

  // Offsets past the table have upper bits set
  assign in_range = (paddr_i[31:REGION_BITS+2] == '0);

  // APB access phase
  assign access = psel_i && penable_i;
  assign wr_en  = access && pwrite_i && in_range;

  // Legalize each half before storing
  assign wr_raw             = pma_reg_t'(pwdata_i);
  assign wr_legal.pma_cfg_1 = legalize(wr_raw.pma_cfg_1);
  assign wr_legal.pma_cfg_0 = legalize(wr_raw.pma_cfg_0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= reset_value(i);
      end
    end else if (wr_en) begin
      regs[reg_idx] <= wr_legal;
    end
  end

  // No wait states
  assign pready_o = 1'b1;

  // Error only in the access cycle of a bad offset
  assign pslverr_o = access && !in_range;

  // Read data is zero for bad offsets and writes
  always_comb begin
    prdata_o = '0;
    if (psel_i && !pwrite_i && in_range) begin
      prdata_o = regs[reg_idx];
    end
  end

  // Lookup ports for the checker
  assign lookup.d_entry = regs[lookup.d_idx];
  assign lookup.i_entry = regs[lookup.i_idx];

endmodule

// ==== source/pma_cfg_pkg.sv ====
package pma_cfg_pkg;

  // Widest access a region accepts
  typedef enum logic [1:0] {
    ByteAcc          = 2'd0,
    HalfAcc          = 2'd1,
    WordAcc          = 2'd2,
    AccWidthReserved = 2'd3
  } acc_width_t;

  // LR/SC reservability class
  typedef enum logic [1:0] {
    RsrvNone,
    RsrvNonEventual,
    RsrvEventual,
    RsrvReserved
  } rsrv_t;

  // Atomic operation class
  typedef enum logic [2:0] {
    AMONone,
    AMOSwap,
    AMOLogical,
    AMOArithmetic
  } amo_t;

  // One region configuration, 16 bits
  typedef struct packed {
    logic [1:0] reserved;
    logic       W;
    logic       R;
    logic       X;
    acc_width_t AccWidth;
    logic       Idm;
    logic       Cache;
    logic       Coh;
    rsrv_t      Rsrv;
    amo_t       AMO;
    // Set for memory and clear for I/O
    logic       Memory;
  } pma_cfg_t;

  // Two regions per attribute register
  typedef struct packed {
    pma_cfg_t pma_cfg_1;
    pma_cfg_t pma_cfg_0;
  } pma_reg_t;

  // Boot ROM without write permission
  localparam pma_cfg_t ROM_CFG = '{
    reserved: 2'b00, W: 1'b0, R: 1'b1, X: 1'b1, AccWidth: WordAcc,
    Idm: 1'b1, Cache: 1'b1, Coh: 1'b1, Rsrv: RsrvEventual,
    AMO: AMONone, Memory: 1'b1
  };

  // Main memory
  localparam pma_cfg_t RAM_CFG = '{
    reserved: 2'b00, W: 1'b1, R: 1'b1, X: 1'b1, AccWidth: WordAcc,
    Idm: 1'b1, Cache: 1'b1, Coh: 1'b1, Rsrv: RsrvEventual,
    AMO: AMONone, Memory: 1'b1
  };

  // Peripheral space with side effects on access
  localparam pma_cfg_t IO_CFG = '{
    reserved: 2'b00, W: 1'b1, R: 1'b1, X: 1'b1, AccWidth: WordAcc,
    Idm: 1'b0, Cache: 1'b0, Coh: 1'b1, Rsrv: RsrvEventual,
    AMO: AMONone, Memory: 1'b0
  };

endpackage

// ==== source/pma_checker.sv ====
`timescale 1ns/1ps

module pma_checker #(
  parameter int ADDR_W      = mem_access_pkg::ADDR_W_DEFAULT,
  parameter int REGION_BITS = 4
) (
  input  logic [ADDR_W-1:0]      d_addr_i,
  input  logic                   d_ren_i,
  input  logic                   d_wen_i,
  input  pma_cfg_pkg::acc_width_t d_width_i,
  input  logic [ADDR_W-1:0]      i_addr_i,
  input  logic                   i_xen_i,
  input  pma_cfg_pkg::acc_width_t i_width_i,
  pma_lookup_if.chk              lookup,
  pma_fault_if.chk               fault
);

  import pma_cfg_pkg::*;

  // Bit just below the region index picks the half
  localparam int HALF_BIT = ADDR_W - REGION_BITS - 1;

  pma_cfg_t d_cfg;
  pma_cfg_t i_cfg;
  logic     d_wide;
  logic     i_wide;

  // Region index from the top address bits
  assign lookup.d_idx = d_addr_i[ADDR_W-1 -: REGION_BITS];
  assign lookup.i_idx = i_addr_i[ADDR_W-1 -: REGION_BITS];

  // Half selection
  assign d_cfg = d_addr_i[HALF_BIT] ? lookup.d_entry.pma_cfg_1 : lookup.d_entry.pma_cfg_0;
  assign i_cfg = i_addr_i[HALF_BIT] ? lookup.i_entry.pma_cfg_1 : lookup.i_entry.pma_cfg_0;

  // Request wider than the region allows
  assign d_wide = (d_width_i > d_cfg.AccWidth);
  assign i_wide = (i_width_i > i_cfg.AccWidth);

  // Load first, then store, then fetch
  always_comb begin
    fault.l_fault = 1'b0;
    fault.s_fault = 1'b0;
    fault.i_fault = 1'b0;
    if (d_ren_i && (!d_cfg.R || d_wide)) begin
      fault.l_fault = 1'b1;
    end else if (d_wen_i && (!d_cfg.W || d_wide)) begin
      fault.s_fault = 1'b1;
    end else if (i_xen_i && (!i_cfg.X || i_wide)) begin
      fault.i_fault = 1'b1;
    end
  end

  // Addresses pass on for reporting
  assign fault.d_addr = d_addr_i;
  assign fault.i_addr = i_addr_i;

endmodule

// ==== source/pma_fault_if.sv ====
`timescale 1ns/1ps

interface pma_fault_if #(
  parameter int ADDR_W = mem_access_pkg::ADDR_W_DEFAULT
);

  // Raw fault flags that are one hot or all clear
  logic l_fault;
  logic s_fault;
  logic i_fault;

  // Addresses of the access under check
  logic [ADDR_W-1:0] d_addr;
  logic [ADDR_W-1:0] i_addr;

  // Checker side
  modport chk (
    output l_fault, s_fault, i_fault, d_addr, i_addr
  );

  // Output side
  modport report (
    input l_fault, s_fault, i_fault, d_addr, i_addr
  );

endinterface

// ==== source/pma_fault_report.sv ====
`timescale 1ns/1ps

module pma_fault_report #(
  parameter int ADDR_W = mem_access_pkg::ADDR_W_DEFAULT
) (
  input  logic                        CLK,
  input  logic                        nRST,
  pma_fault_if.report                 fault,
  output logic                        fault_valid_o,
  output mem_access_pkg::fault_cause_t fault_cause_o,
  output logic [ADDR_W-1:0]           fault_addr_o
);

  import mem_access_pkg::*;

  logic              valid_d;
  fault_cause_t      cause_d;
  logic [ADDR_W-1:0] addr_d;

  // Flags are one hot so the chain only sets the order
  always_comb begin
    cause_d = NoFault;
    addr_d  = '0;
    if (fault.l_fault) begin
      cause_d = LoadAccessFault;
      addr_d  = fault.d_addr;
    end else if (fault.s_fault) begin
      cause_d = StoreAccessFault;
      addr_d  = fault.d_addr;
    end else if (fault.i_fault) begin
      cause_d = InstrAccessFault;
      addr_d  = fault.i_addr;
    end
  end

  assign valid_d = fault.l_fault || fault.s_fault || fault.i_fault;

  // One cycle of latency with a new result every cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fault_valid_o <= 1'b0;
      fault_cause_o <= NoFault;
      fault_addr_o  <= '0;
    end else begin
      fault_valid_o <= valid_d;
      fault_cause_o <= cause_d;
      fault_addr_o  <= addr_d;
    end
  end

endmodule

// ==== source/pma_lookup_if.sv ====
`timescale 1ns/1ps

interface pma_lookup_if #(
  parameter int REGION_BITS = 4
);

  import pma_cfg_pkg::*;

  // Register indices from the top address bits
  logic [REGION_BITS-1:0] d_idx;
  logic [REGION_BITS-1:0] i_idx;

  // Table entries returned in the same cycle
  pma_reg_t d_entry;
  pma_reg_t i_entry;

  // Register block side
  modport regs (
    input  d_idx, i_idx,
    output d_entry, i_entry
  );

  // Checker side
  modport chk (
    output d_idx, i_idx,
    input  d_entry, i_entry
  );

endinterface

// ==== source/pma_top.sv ====
`timescale 1ns/1ps

module pma_top #(
  parameter int ADDR_W      = mem_access_pkg::ADDR_W_DEFAULT,
  parameter int REGION_BITS = 4
) (
  input  logic                         CLK,
  input  logic                         nRST,
  // APB3 slave
  input  logic                         PSEL_i,
  input  logic                         PENABLE_i,
  input  logic                         PWRITE_i,
  input  logic [31:0]                  PADDR_i,
  input  logic [31:0]                  PWDATA_i,
  output logic [31:0]                  PRDATA_o,
  output logic                         PREADY_o,
  output logic                         PSLVERR_o,
  // Data side access
  input  logic [ADDR_W-1:0]            d_addr_i,
  input  logic                         d_ren_i,
  input  logic                         d_wen_i,
  input  pma_cfg_pkg::acc_width_t      d_width_i,
  // Fetch side access
  input  logic [ADDR_W-1:0]            i_addr_i,
  input  logic                         i_xen_i,
  input  pma_cfg_pkg::acc_width_t      i_width_i,
  // Registered fault report
  output logic                         fault_valid_o,
  output mem_access_pkg::fault_cause_t fault_cause_o,
  output logic [ADDR_W-1:0]            fault_addr_o
);

  // Table read path and fault path
  pma_lookup_if #(.REGION_BITS(REGION_BITS)) lookup_bus ();
  pma_fault_if  #(.ADDR_W(ADDR_W))           fault_bus ();

  // Register table behind APB
  pma_apb_regs #(
    .REGION_BITS (REGION_BITS)
  ) u_regs (
    .CLK       (CLK),
    .nRST      (nRST),
    .psel_i    (PSEL_i),
    .penable_i (PENABLE_i),
    .pwrite_i  (PWRITE_i),
    .paddr_i   (PADDR_i),
    .pwdata_i  (PWDATA_i),
    .prdata_o  (PRDATA_o),
    .pready_o  (PREADY_o),
    .pslverr_o (PSLVERR_o),
    .lookup    (lookup_bus.regs)
  );

  // Combinational permission check
  pma_checker #(
    .ADDR_W      (ADDR_W),
    .REGION_BITS (REGION_BITS)
  ) u_checker (
    .d_addr_i  (d_addr_i),
    .d_ren_i   (d_ren_i),
    .d_wen_i   (d_wen_i),
    .d_width_i (d_width_i),
    .i_addr_i  (i_addr_i),
    .i_xen_i   (i_xen_i),
    .i_width_i (i_width_i),
    .lookup    (lookup_bus.chk),
    .fault     (fault_bus.chk)
  );

  // Cause encoding and output register
  pma_fault_report #(
    .ADDR_W (ADDR_W)
  ) u_report (
    .CLK           (CLK),
    .nRST          (nRST),
    .fault         (fault_bus.report),
    .fault_valid_o (fault_valid_o),
    .fault_cause_o (fault_cause_o),
    .fault_addr_o  (fault_addr_o)
  );

endmodule

// ==== verif/pma_props.sv ====
`timescale 1ns/1ps

module pma_props (
  input logic                         CLK,
  input logic                         nRST,
  input logic                         psel_i,
  input logic                         penable_i,
  input logic                         pwrite_i,
  input logic [31:0]                  prdata_i,
  input logic                         pready_i,
  input logic                         fault_valid_i,
  input mem_access_pkg::fault_cause_t fault_cause_i
);

  import mem_access_pkg::*;

  // Number of failed assertions
  int unsigned fail_count = 0;

  logic rd_access;

  // APB read in its access cycle
  assign rd_access = psel_i && penable_i && !pwrite_i;

  // Idle output carries no cause
  idle_cause_zero: assert property (@(posedge CLK) disable iff (!nRST)
    !fault_valid_i |-> fault_cause_i == NoFault)
    else begin
      $error("fault cause is nonzero while fault_valid is low");
      fail_count++;
    end

  // No wait states ever
  pready_high: assert property (@(posedge CLK) disable iff (!nRST) pready_i)
    else begin
      $error("PREADY dropped low");
      fail_count++;
    end

  // Valid cause is an access fault code
  cause_legal: assert property (@(posedge CLK) disable iff (!nRST)
    fault_valid_i |-> fault_cause_i inside {InstrAccessFault, LoadAccessFault,
                                            StoreAccessFault})
    else begin
      $error("fault cause is not an access fault code");
      fail_count++;
    end

  // Both halves hold a legal width
  rd_width_legal: assert property (@(posedge CLK) disable iff (!nRST)
    rd_access |-> (prdata_i[26:25] != 2'b11) && (prdata_i[10:9] != 2'b11))
    else begin
      $error("readback holds a reserved access width");
      fail_count++;
    end

endmodule

bind pma_top pma_props u_props (
  .CLK           (CLK),
  .nRST          (nRST),
  .psel_i        (PSEL_i),
  .penable_i     (PENABLE_i),
  .pwrite_i      (PWRITE_i),
  .prdata_i      (PRDATA_o),
  .pready_i      (PREADY_o),
  .fault_valid_i (fault_valid_o),
  .fault_cause_i (fault_cause_o)
);

// ==== verif/pma_scoreboard.sv ====
`timescale 1ns/1ps

module pma_scoreboard #(
  parameter int ADDR_W      = 32,
  parameter int REGION_BITS = 4
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [31:0]                  paddr_i,
  input  logic [31:0]                  pwdata_i,
  input  logic [31:0]                  prdata_i,
  input  logic                         pslverr_i,
  input  logic [ADDR_W-1:0]            d_addr_i,
  input  logic                         d_ren_i,
  input  logic                         d_wen_i,
  input  pma_cfg_pkg::acc_width_t      d_width_i,
  input  logic [ADDR_W-1:0]            i_addr_i,
  input  logic                         i_xen_i,
  input  pma_cfg_pkg::acc_width_t      i_width_i,
  input  logic                         fault_valid_i,
  input  mem_access_pkg::fault_cause_t fault_cause_i,
  input  logic [ADDR_W-1:0]            fault_addr_i,
  // Fixed expectation from the stimulus table
  input  logic                         exp_en_i,
  input  logic [31:0]                  exp_val_i,
  output logic [31:0]                  err_count_o
);

  import pma_cfg_pkg::*;
  import mem_access_pkg::*;

  localparam int NUM_REGS = 2 ** REGION_BITS;
  localparam int HALF_BIT = ADDR_W - REGION_BITS - 1;
  // Bit positions inside one 16-bit region config
  localparam int W_BIT = 13;
  localparam int R_BIT = 12;
  localparam int X_BIT = 11;

  logic [31:0]            model [NUM_REGS];
  logic [3:0]             pend_cause = 4'd0;
  logic [ADDR_W-1:0]      pend_addr = '0;
  logic                   pend_tbl = 1'b0;
  logic [3:0]             pend_tbl_cause = 4'd0;
  logic [31:0]            errors = 32'd0;
  logic                   apb_access;
  logic                   apb_in_range;
  logic [REGION_BITS-1:0] apb_idx;

  assign err_count_o  = errors;
  assign apb_access   = psel_i && penable_i;
  assign apb_idx      = paddr_i[REGION_BITS+1:2];
  assign apb_in_range = (paddr_i >> (REGION_BITS + 2)) == 32'd0;

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("MISMATCH at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
    errors = errors + 32'd1;
  endtask

  // Reserved width to word and reserved Rsrv to none
  function automatic logic [15:0] warl(input logic [15:0] cfg);
    logic [15:0] res;
    res = cfg;
    if (res[10:9] == 2'b11) begin
      res[10:9] = 2'b10;
    end
    if (res[5:4] == 2'b11) begin
      res[5:4] = 2'b00;
    end
    return res;
  endfunction

  function automatic logic [15:0] region_cfg(input logic [ADDR_W-1:0] addr);
    logic [31:0] entry;
    entry = model[addr[ADDR_W-1 -: REGION_BITS]];
    return addr[HALF_BIT] ? entry[31:16] : entry[15:0];
  endfunction

  task automatic reset_model();
    for (int i = 0; i < NUM_REGS; i++) begin
      if (i == 0) begin
        model[i] = {RAM_CFG, ROM_CFG};
      end else if (i < NUM_REGS / 2) begin
        model[i] = {RAM_CFG, RAM_CFG};
      end else begin
        model[i] = {IO_CFG, IO_CFG};
      end
    end
  endtask

  // Load beats store beats fetch
  task automatic predict_fault();
    logic [15:0] dc;
    logic [15:0] ic;
    dc = region_cfg(d_addr_i);
    ic = region_cfg(i_addr_i);
    pend_cause = 4'd0;
    pend_addr  = '0;
    if (d_ren_i && (!dc[R_BIT] || d_width_i > dc[10:9])) begin
      pend_cause = LoadAccessFault;
      pend_addr  = d_addr_i;
    end else if (d_wen_i && (!dc[W_BIT] || d_width_i > dc[10:9])) begin
      pend_cause = StoreAccessFault;
      pend_addr  = d_addr_i;
    end else if (i_xen_i && (!ic[X_BIT] || i_width_i > ic[10:9])) begin
      pend_cause = InstrAccessFault;
      pend_addr  = i_addr_i;
    end
  endtask

  task automatic check_outputs();
    logic [31:0] exp_rd;
    if (fault_valid_i !== (pend_cause != 4'd0)) begin
      mismatch("fault_valid_o", 32'(pend_cause != 4'd0), 32'(fault_valid_i));
    end
    if (fault_cause_i !== pend_cause) begin
      mismatch("fault_cause_o", 32'(pend_cause), 32'(fault_cause_i));
    end
    if (pend_cause != 4'd0 && fault_addr_i !== pend_addr) begin
      mismatch("fault_addr_o", 32'(pend_addr), 32'(fault_addr_i));
    end
    if (pend_tbl && fault_cause_i !== pend_tbl_cause) begin
      mismatch("fault_cause_o (table)", 32'(pend_tbl_cause), 32'(fault_cause_i));
    end
    if (pslverr_i !== (apb_access && !apb_in_range)) begin
      mismatch("PSLVERR_o", 32'(apb_access && !apb_in_range), 32'(pslverr_i));
    end
    if (apb_access && !pwrite_i) begin
      exp_rd = apb_in_range ? model[apb_idx] : 32'd0;
      if (prdata_i !== exp_rd) begin
        mismatch("PRDATA_o", exp_rd, prdata_i);
      end
      if (exp_en_i && prdata_i !== exp_val_i) begin
        mismatch("PRDATA_o (table)", exp_val_i, prdata_i);
      end
    end
  endtask

  // Sample mid-cycle while inputs and outputs are settled
  always @(negedge CLK) begin
    if (!nRST) begin
      reset_model();
      pend_cause = 4'd0;
      pend_tbl   = 1'b0;
    end else begin
      check_outputs();
      // Access this cycle still sees the old table
      predict_fault();
      pend_tbl       = exp_en_i && !(apb_access && !pwrite_i);
      pend_tbl_cause = exp_val_i[3:0];
      if (apb_access && pwrite_i && apb_in_range) begin
        model[apb_idx] = {warl(pwdata_i[31:16]), warl(pwdata_i[15:0])};
      end
    end
  end

endmodule

// ==== verif/pma_tb.sv ====
`timescale 1ns/1ps

module pma_tb;

  import pma_cfg_pkg::*;
  import mem_access_pkg::*;

  localparam int ADDR_W        = 32;
  localparam int REGION_BITS   = 4;
  localparam int CLK_PERIOD    = 20;
  localparam int RAND_ACCESSES = 200;

  typedef enum logic [1:0] {
    ApbWrite,
    ApbRead,
    Access
  } step_kind_e;

  // One table row with read data or cause in exp
  typedef struct packed {
    step_kind_e  kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic        ren;
    logic        wen;
    acc_width_t  dw;
    logic [31:0] iaddr;
    logic        xen;
    acc_width_t  iw;
    logic [31:0] exp;
  } step_t;

  logic CLK = 1'b0;
  logic nRST;
  logic psel, penable, pwrite, pready, pslverr;
  logic [31:0] paddr, pwdata, prdata;
  logic [ADDR_W-1:0] d_addr, i_addr, fault_addr;
  logic d_ren, d_wen, i_xen, fault_valid;
  acc_width_t d_width, i_width;
  fault_cause_t fault_cause;
  logic exp_en;
  logic [31:0] exp_val, err_count;
  step_t steps[$];
  int seed = 32'h49b2d08c;

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  pma_top #(.ADDR_W(ADDR_W), .REGION_BITS(REGION_BITS)) uut (
    .CLK(CLK), .nRST(nRST),
    .PSEL_i(psel), .PENABLE_i(penable), .PWRITE_i(pwrite), .PADDR_i(paddr),
    .PWDATA_i(pwdata), .PRDATA_o(prdata), .PREADY_o(pready), .PSLVERR_o(pslverr),
    .d_addr_i(d_addr), .d_ren_i(d_ren), .d_wen_i(d_wen), .d_width_i(d_width),
    .i_addr_i(i_addr), .i_xen_i(i_xen), .i_width_i(i_width),
    .fault_valid_o(fault_valid), .fault_cause_o(fault_cause), .fault_addr_o(fault_addr)
  );

  pma_scoreboard #(.ADDR_W(ADDR_W), .REGION_BITS(REGION_BITS)) sb (
    .CLK(CLK), .nRST(nRST),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_i(prdata), .pslverr_i(pslverr),
    .d_addr_i(d_addr), .d_ren_i(d_ren), .d_wen_i(d_wen), .d_width_i(d_width),
    .i_addr_i(i_addr), .i_xen_i(i_xen), .i_width_i(i_width),
    .fault_valid_i(fault_valid), .fault_cause_i(fault_cause), .fault_addr_i(fault_addr),
    .exp_en_i(exp_en), .exp_val_i(exp_val), .err_count_o(err_count)
  );

  task automatic add_write(input logic [31:0] addr, input logic [31:0] data);
    step_t s;
    s = '0;
    s.kind = ApbWrite;
    s.addr = addr;
    s.data = data;
    steps.push_back(s);
  endtask

  task automatic add_read(input logic [31:0] addr, input logic [31:0] exp);
    step_t s;
    s = '0;
    s.kind = ApbRead;
    s.addr = addr;
    s.exp  = exp;
    steps.push_back(s);
  endtask

  task automatic add_access(input logic [31:0] daddr, input logic ren, input logic wen,
                            input acc_width_t dw, input logic [31:0] iaddr,
                            input logic xen, input acc_width_t iw, input fault_cause_t cause);
    step_t s;
    s = '0;
    s.kind  = Access;
    s.addr  = daddr;
    s.ren   = ren;
    s.wen   = wen;
    s.dw    = dw;
    s.iaddr = iaddr;
    s.xen   = xen;
    s.iw    = iw;
    s.exp   = 32'(cause);
    steps.push_back(s);
  endtask

  task automatic build_table();
    // Reset map with ROM under RAM in register 0 and I/O above
    add_read(32'h0000_0000, {RAM_CFG, ROM_CFG});
    add_read(32'h0000_0020, {IO_CFG, IO_CFG});
    add_access(32'h0000_0100, 1'b0, 1'b1, WordAcc, 32'h0, 1'b0, WordAcc, StoreAccessFault);
    add_access(32'h0000_0200, 1'b1, 1'b0, WordAcc, 32'h300, 1'b1, WordAcc, NoFault);
    add_access(32'h8000_0000, 1'b1, 1'b0, WordAcc, 32'h9800_0000, 1'b1, WordAcc, NoFault);
    add_access(32'h8800_0004, 1'b0, 1'b1, WordAcc, 32'h0, 1'b0, WordAcc, NoFault);
    // High half has reserved width and Rsrv
    add_write(32'h0000_000C, 32'h3773_2C21);
    add_read(32'h0000_000C, 32'h3543_2C21);
    add_access(32'h3800_0010, 1'b1, 1'b0, WordAcc, 32'h0, 1'b0, WordAcc, NoFault);
    add_access(32'h3000_0010, 1'b1, 1'b0, WordAcc, 32'h0, 1'b0, WordAcc, LoadAccessFault);
    add_access(32'h3000_0014, 1'b0, 1'b1, WordAcc, 32'h0, 1'b0, WordAcc, NoFault);
    // Region pair 5 byte wide without execute
    add_write(32'h0000_0014, 32'h31C1_31C1);
    add_access(32'h5000_0010, 1'b1, 1'b0, HalfAcc, 32'h0, 1'b0, WordAcc, LoadAccessFault);
    add_access(32'h5000_0011, 1'b1, 1'b0, ByteAcc, 32'h0, 1'b0, WordAcc, NoFault);
    add_access(32'h0, 1'b0, 1'b0, ByteAcc, 32'h5800_0040, 1'b1, WordAcc, InstrAccessFault);
    add_access(32'h0, 1'b0, 1'b0, ByteAcc, 32'h5000_0041, 1'b1, ByteAcc, InstrAccessFault);
    // Priority of load over store over fetch
    add_access(32'h5000_0020, 1'b1, 1'b1, HalfAcc, 32'h5800_0000, 1'b1, WordAcc,
               LoadAccessFault);
    add_access(32'h5000_0030, 1'b0, 1'b1, HalfAcc, 32'h5800_0000, 1'b1, WordAcc,
               StoreAccessFault);
    // Read only low half under a full RAM high half
    add_write(32'h0000_0018, 32'h3DE1_15E1);
    add_access(32'h6000_0000, 1'b0, 1'b1, WordAcc, 32'h0, 1'b0, WordAcc, StoreAccessFault);
    add_access(32'h6800_0000, 1'b0, 1'b1, WordAcc, 32'h0, 1'b0, WordAcc, NoFault);
    add_access(32'h0, 1'b0, 1'b0, WordAcc, 32'h6000_0100, 1'b1, WordAcc, InstrAccessFault);
    add_access(32'h0, 1'b0, 1'b0, WordAcc, 32'h6800_0100, 1'b1, WordAcc, NoFault);
    // Offset 16 is past the table with the index bits of register 0
    add_write(32'h0000_0040, 32'h0000_0000);
    add_read(32'h0000_0040, 32'h0000_0000);
    add_read(32'h0000_0000, {RAM_CFG, ROM_CFG});
  endtask

  task automatic drive_idle();
    psel    <= 1'b0;
    penable <= 1'b0;
    d_ren   <= 1'b0;
    d_wen   <= 1'b0;
    i_xen   <= 1'b0;
    exp_en  <= 1'b0;
  endtask

  task automatic apply_step(input step_t s);
    @(posedge CLK);
    if (s.kind == Access) begin
      d_addr  <= s.addr;
      d_ren   <= s.ren;
      d_wen   <= s.wen;
      d_width <= s.dw;
      i_addr  <= s.iaddr;
      i_xen   <= s.xen;
      i_width <= s.iw;
      exp_en  <= 1'b1;
      exp_val <= s.exp;
    end else begin
      // Setup cycle then access cycle
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= (s.kind == ApbWrite);
      paddr   <= s.addr;
      pwdata  <= s.data;
      @(posedge CLK);
      penable <= 1'b1;
      exp_en  <= (s.kind == ApbRead);
      exp_val <= s.exp;
    end
    @(posedge CLK);
    drive_idle();
  endtask

  // Reserved code folds to byte
  function automatic acc_width_t pick_width(input logic [1:0] w);
    return (w == 2'd3) ? ByteAcc : acc_width_t'(w);
  endfunction

  initial begin
    logic [31:0] r;
    logic [31:0] fails;
    nRST = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    d_addr = '0;
    d_ren = 1'b0;
    d_wen = 1'b0;
    d_width = ByteAcc;
    i_addr = '0;
    i_xen = 1'b0;
    i_width = ByteAcc;
    exp_en = 1'b0;
    exp_val = '0;
    build_table();
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    foreach (steps[k]) begin
      apply_step(steps[k]);
    end
    // Back to back random accesses
    for (int n = 0; n < RAND_ACCESSES; n++) begin
      @(posedge CLK);
      r = $random(seed);
      d_addr  <= $random(seed);
      i_addr  <= $random(seed);
      d_ren   <= r[0];
      d_wen   <= r[1];
      i_xen   <= r[2];
      d_width <= pick_width(r[5:4]);
      i_width <= pick_width(r[7:6]);
    end
    @(posedge CLK);
    drive_idle();
    repeat (2) @(posedge CLK);
    fails = err_count + uut.u_props.fail_count;
    $display("Run complete: %0d scoreboard errors, %0d assertion failures",
             err_count, uut.u_props.fail_count);
    if (fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Up to three cycles per row plus random phase and slack
  initial begin : watchdog
    longint limit;
    #1;
    limit = (longint'(steps.size()) * 3 + RAND_ACCESSES + 20) * CLK_PERIOD;
    #(limit - 1);
    $display("Watchdog expired: stimulus did not complete within %0d ns", limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule
